/* Makefile */
# Verilator build and run of the pipeline testbench

VERILATOR ?= verilator
TOP ?= tb_rv_pipeline
FLAGS ?=

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check for the pass message"
	@echo "  clean  remove the build directory"
	@echo "  help   list these targets"

test:
	$(VERILATOR) --binary --top-module $(TOP) -f src.f $(FLAGS)
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf obj_dir

/* src.f */
+incdir+testbench
verilog/rv_pipe_pkg.sv
verilog/insn_mem.sv
verilog/reg_file.sv
verilog/fetch_stage.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/retire_stage.sv
verilog/rv_pipeline.sv
testbench/tb_rv_pipeline.sv

/* testbench/rv_isa_model.svh */
`ifndef RV_ISA_MODEL_SVH
`define RV_ISA_MODEL_SVH

// architectural state of the reference model
logic [xlen-1:0] model_mem [imem_words];
logic [xlen-1:0] model_regs [num_regs];
logic [xlen-1:0] model_pc;

// u-type lui
function automatic logic [xlen-1:0] enc_lui(input logic [4:0] rd, input logic [19:0] imm);
  return {imm, rd, 7'b0110111};
endfunction

// i-type addi
function automatic logic [xlen-1:0] enc_addi(input logic [4:0] rd, input logic [4:0] rs1,
                                            input logic [11:0] imm);
  return {imm, rs1, 3'b000, rd, 7'b0010011};
endfunction

// r-type add
function automatic logic [xlen-1:0] enc_add(input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [4:0] rs2);
  return {7'b0000000, rs2, rs1, 3'b000, rd, 7'b0110011};
endfunction

// b-type, funct3 000 for beq and 001 for bne
function automatic logic [xlen-1:0] enc_branch(input logic is_bne, input logic [4:0] rs1,
                                              input logic [4:0] rs2, input logic [12:0] off);
  return {off[12], off[10:5], rs2, rs1, 2'b00, is_bne, off[4:1], off[11], 7'b1100011};
endfunction

// one random word, registers x0..x7 keep dependences dense
function automatic logic [xlen-1:0] random_insn();
  logic [4:0] rd;
  logic [4:0] rs1;
  logic [4:0] rs2;
  logic [12:0] off;
  int unsigned pick;
  rd = 5'($urandom_range(7));
  rs1 = 5'($urandom_range(7));
  rs2 = 5'($urandom_range(7));
  // forward only, 8, 12 or 16 bytes
  off = 13'(8 + 4 * $urandom_range(2));
  pick = $urandom_range(19);
  if (pick == 0) begin
    // custom-0 opcode, outside the subset
    return {$urandom()} & 32'hffff_ff80 | 32'h0000_000b;
  end else if (pick < 4) begin
    return enc_lui(rd, 20'($urandom()));
  end else if (pick < 10) begin
    return enc_addi(rd, rs1, 12'($urandom()));
  end else if (pick < 15) begin
    return enc_add(rd, rs1, rs2);
  end else begin
    return enc_branch(pick >= 17, rs1, rs2, off);
  end
endfunction

task automatic model_reset();
  model_pc = reset_pc;
  for (int i = 0; i < num_regs; i++) begin
    model_regs[i] = '0;
  end
endtask

// execute one instruction and report what it retires
task automatic model_step(output logic [xlen-1:0] pc, output logic [xlen-1:0] insn,
                          output logic we, output logic [reg_addr_w-1:0] rd,
                          output logic [xlen-1:0] data, output logic taken);
  logic [xlen-1:0] a;
  logic [xlen-1:0] b;
  logic [xlen-1:0] next_pc;
  logic [xlen-1:0] boff;
  // fetch wraps around the memory image
  insn = model_mem[model_pc[imem_addr_w+1:2]];
  rd = insn[11:7];
  a = model_regs[insn[19:15]];
  b = model_regs[insn[24:20]];
  boff = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
  we = 1'b0;
  data = '0;
  taken = 1'b0;
  next_pc = model_pc + pc_step;
  case (insn[6:0])
    7'b0110111: begin
      we = 1'b1;
      data = {insn[31:12], 12'b0};
    end
    7'b0010011: begin
      we = (insn[14:12] == 3'b000);
      data = a + {{20{insn[31]}}, insn[31:20]};
    end
    7'b0110011: begin
      we = (insn[14:12] == 3'b000) && (insn[31:25] == 7'b0000000);
      data = a + b;
    end
    7'b1100011: begin
      if (insn[14:13] == 2'b00) begin
        taken = insn[12] ? (a != b) : (a == b);
      end
    end
    default: begin
      we = 1'b0;
    end
  endcase
  // x0 is never written, illegal words write nothing
  if (rd == 5'd0) begin
    we = 1'b0;
  end
  if (we) begin
    model_regs[rd] = data;
  end
  if (taken) begin
    next_pc = model_pc + boff;
  end
  pc = model_pc;
  model_pc = next_pc;
endtask

`endif

/* testbench/tb_rv_pipeline.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_rv_pipeline;
  import rv_pipe_pkg::*;

  // retirements checked before the run ends
  localparam int num_retire = 400;
  // widest gap between retirements is two squashed slots
  localparam int retire_timeout = 6;
  // four drain cycles plus margin
  localparam int reset_timeout = 12;

  logic clk;
  logic rst;
  logic load_en;
  logic [imem_addr_w-1:0] load_addr;
  logic [xlen-1:0] load_data;

  logic [xlen-1:0] trace_pc;
  logic [xlen-1:0] trace_insn;
  cycle_status_e trace_status;
  logic trace_rd_we;
  logic [reg_addr_w-1:0] trace_rd;
  logic [xlen-1:0] trace_rd_data;

  `include "rv_isa_model.svh"

  rv_pipeline dut (
    .clk           (clk),
    .rst           (rst),
    .load_en       (load_en),
    .load_addr     (load_addr),
    .load_data     (load_data),
    .trace_pc      (trace_pc),
    .trace_insn    (trace_insn),
    .trace_status  (trace_status),
    .trace_rd_we   (trace_rd_we),
    .trace_rd      (trace_rd),
    .trace_rd_data (trace_rd_data)
  );

  // 100 ns period
  initial clk = 1'b0;
  always #50 clk = ~clk;

  task automatic abort_run();
    $display("*** FAILED ***");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [xlen-1:0] expected,
                             input logic [xlen-1:0] actual);
    if (actual !== expected) begin
      $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
      abort_run();
    end
  endtask

  // step to the next live writeback slot, every bubble on the way must match
  task automatic wait_for_retirement(input cycle_status_e bubble, input int limit,
                                     output int bubbles);
    bubbles = 0;
    @(negedge clk);
    while (trace_status != cycle_no_stall) begin
      check_value("bubble status", 32'(bubble), 32'(trace_status));
      check_value("bubble rd_we", '0, 32'(trace_rd_we));
      bubbles++;
      if (bubbles > limit) begin
        $display("timeout: no instruction retired within %0d cycles", limit);
        abort_run();
      end
      @(negedge clk);
    end
  endtask

  initial begin
    int bubbles;
    int expect_squash;
    logic [xlen-1:0] word;
    logic [xlen-1:0] exp_pc;
    logic [xlen-1:0] exp_insn;
    logic exp_we;
    logic [reg_addr_w-1:0] exp_rd;
    logic [xlen-1:0] exp_data;
    logic exp_taken;

    void'($urandom(52629));
    rst <= 1'b1;
    load_en <= 1'b0;
    load_addr <= '0;
    load_data <= '0;
    model_reset();

    // program load while reset is held, trace stays in reset
    for (int i = 0; i < imem_words; i++) begin
      word = random_insn();
      model_mem[i] = word;
      @(posedge clk);
      load_en <= 1'b1;
      load_addr <= imem_addr_w'(i);
      load_data <= word;
      @(negedge clk);
      check_value("reset status during load", 32'(cycle_reset), 32'(trace_status));
      check_value("reset rd_we during load", '0, 32'(trace_rd_we));
    end
    // last word lands on the first of two extra reset cycles
    for (int k = 0; k < 2; k++) begin
      @(posedge clk);
      load_en <= 1'b0;
      @(negedge clk);
      check_value("reset status after load", 32'(cycle_reset), 32'(trace_status));
      check_value("reset rd_we after load", '0, 32'(trace_rd_we));
    end
    @(posedge clk);
    rst <= 1'b0;

    // pipe drains four reset slots before the first retirement
    wait_for_retirement(cycle_reset, reset_timeout, bubbles);
    check_value("reset cycles after release", 32'd4, 32'(bubbles));
    check_value("first retirement pc", reset_pc, trace_pc);

    expect_squash = 0;
    for (int n = 0; n < num_retire; n++) begin
      if (n > 0) begin
        wait_for_retirement(cycle_taken_branch, retire_timeout, bubbles);
        // two squashed slots behind a taken branch, none otherwise
        check_value($sformatf("retire %0d squashed slots", n), 32'(expect_squash),
                    32'(bubbles));
      end
      model_step(exp_pc, exp_insn, exp_we, exp_rd, exp_data, exp_taken);
      check_value($sformatf("retire %0d pc", n), exp_pc, trace_pc);
      check_value($sformatf("retire %0d insn", n), exp_insn, trace_insn);
      check_value($sformatf("retire %0d rd_we", n), 32'(exp_we), 32'(trace_rd_we));
      if (exp_we) begin
        check_value($sformatf("retire %0d rd", n), 32'(exp_rd), 32'(trace_rd));
        check_value($sformatf("retire %0d rd_data", n), exp_data, trace_rd_data);
      end
      expect_squash = exp_taken ? 2 : 0;
    end

    $display("*** PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

/* verilog/decode_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module decode_stage (
  input wire clk,
  input wire rst,
  input wire rv_pipe_pkg::fetch_decode_t from_fetch,
  input wire rv_pipe_pkg::reg_write_t wb_write,
  input wire redirect,
  output rv_pipe_pkg::decode_execute_t to_execute
);
  import rv_pipe_pkg::*;

  // instruction fields
  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic [reg_addr_w-1:0] rd;
  logic [reg_addr_w-1:0] rs1;
  logic [reg_addr_w-1:0] rs2;

  // immediate formats
  logic [xlen-1:0] imm_i;
  logic [xlen-1:0] imm_u;
  logic [xlen-1:0] imm_b;

  // register file read data before the bypass
  logic [xlen-1:0] rf_rs1_data;
  logic [xlen-1:0] rf_rs2_data;

  insn_op_e op;
  logic [xlen-1:0] imm;
  logic writes_rd;
  decode_execute_t next_rec;

  assign {funct7, rs2, rs1, funct3, rd, opcode} = from_fetch.insn;

  assign imm_i = {{20{from_fetch.insn[31]}}, from_fetch.insn[31:20]};
  assign imm_u = {from_fetch.insn[31:12], 12'b0};
  // b-type offset is scattered and always even
  assign imm_b = {{19{from_fetch.insn[31]}}, from_fetch.insn[31], from_fetch.insn[7],
                  from_fetch.insn[30:25], from_fetch.insn[11:8], 1'b0};

  reg_file rf (
    .clk      (clk),
    .rst      (rst),
    .wr       (wb_write),
    .rs1_addr (rs1),
    .rs2_addr (rs2),
    .rs1_data (rf_rs1_data),
    .rs2_data (rf_rs2_data)
  );

  // map fields to an operation, anything else is illegal
  always_comb begin
    op = op_illegal;
    imm = '0;
    case (opcode)
      opcode_lui: begin
        op = op_lui;
        imm = imm_u;
      end
      opcode_op_imm: begin
        if (funct3 == 3'b000) begin
          op = op_addi;
          imm = imm_i;
        end
      end
      opcode_op: begin
        if (funct3 == 3'b000 && funct7 == 7'b0000000) begin
          op = op_add;
        end
      end
      opcode_branch: begin
        imm = imm_b;
        if (funct3 == 3'b000) begin
          op = op_beq;
        end else if (funct3 == 3'b001) begin
          op = op_bne;
        end
      end
      default: begin
        op = op_illegal;
      end
    endcase
  end

  assign writes_rd = (op == op_lui) || (op == op_addi) || (op == op_add);

  // next execute record with the same-cycle writeback bypass
  always_comb begin
    next_rec.pc = from_fetch.pc;
    next_rec.insn = from_fetch.insn;
    next_rec.op = op;
    next_rec.rd = rd;
    next_rec.rs1 = rs1;
    next_rec.rs2 = rs2;
    next_rec.rs1_data = (wb_write.we && wb_write.rd == rs1) ? wb_write.data : rf_rs1_data;
    next_rec.rs2_data = (wb_write.we && wb_write.rd == rs2) ? wb_write.data : rf_rs2_data;
    next_rec.imm = imm;
    // only live, writing ops with a nonzero rd ever set the write bit
    next_rec.rd_we = writes_rd && (from_fetch.status == cycle_no_stall) &&
                     (rd != '0) && !redirect;
    next_rec.status = redirect ? cycle_taken_branch : from_fetch.status;
  end

  // decode to execute register
  always_ff @(posedge clk) begin
    to_execute <= next_rec;
    if (rst) begin
      to_execute.status <= cycle_reset;
      to_execute.rd_we <= 1'b0;
    end
  end

endmodule

`default_nettype wire

/* verilog/execute_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module execute_stage (
  input wire rv_pipe_pkg::decode_execute_t from_decode,
  input wire rv_pipe_pkg::reg_write_t mem_fwd,
  input wire rv_pipe_pkg::reg_write_t wb_write,
  output rv_pipe_pkg::execute_memory_t to_memory,
  output logic redirect,
  output logic [rv_pipe_pkg::xlen-1:0] redirect_pc
);
  import rv_pipe_pkg::*;

  // forwarded operands
  logic [xlen-1:0] src1;
  logic [xlen-1:0] src2;

  // shared adder for addi and add
  logic [xlen-1:0] add_b;
  logic [xlen-1:0] sum;
  logic [xlen-1:0] result;

  logic equal;
  logic taken;

  // youngest producer wins, memory ahead of writeback
  function automatic logic [xlen-1:0] fwd_operand(
    input logic [reg_addr_w-1:0] src,
    input logic [xlen-1:0] decoded,
    input reg_write_t mem_src,
    input reg_write_t wb_src
  );
    logic [xlen-1:0] val;
    val = decoded;
    if (wb_src.we && wb_src.rd == src) begin
      val = wb_src.data;
    end
    if (mem_src.we && mem_src.rd == src) begin
      val = mem_src.data;
    end
    return val;
  endfunction

  always_comb begin
    src1 = fwd_operand(from_decode.rs1, from_decode.rs1_data, mem_fwd, wb_write);
    src2 = fwd_operand(from_decode.rs2, from_decode.rs2_data, mem_fwd, wb_write);
  end

  // second adder input is rs2 for add, otherwise the immediate
  assign add_b = (from_decode.op == op_add) ? src2 : from_decode.imm;
  assign sum = src1 + add_b;

  always_comb begin
    case (from_decode.op)
      // imm already holds the upper 20 bits shifted into place
      op_lui: result = from_decode.imm;
      op_addi: result = sum;
      op_add: result = sum;
      default: result = '0;
    endcase
  end

  // branch compare on forwarded values
  assign equal = (src1 == src2);
  always_comb begin
    taken = 1'b0;
    if (from_decode.op == op_beq) begin
      taken = equal;
    end else if (from_decode.op == op_bne) begin
      taken = !equal;
    end
  end

  // squashed or reset slots never redirect
  assign redirect = taken && (from_decode.status == cycle_no_stall);
  // target is relative to the branch itself
  assign redirect_pc = from_decode.pc + from_decode.imm;

  always_comb begin
    to_memory.pc = from_decode.pc;
    to_memory.insn = from_decode.insn;
    to_memory.rd = from_decode.rd;
    to_memory.rd_we = from_decode.rd_we;
    to_memory.result = result;
    to_memory.status = from_decode.status;
  end

endmodule

`default_nettype wire

/* verilog/fetch_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module fetch_stage (
  input wire clk,
  input wire rst,
  input wire [rv_pipe_pkg::xlen-1:0] insn,
  input wire redirect,
  input wire [rv_pipe_pkg::xlen-1:0] redirect_pc,
  output logic [rv_pipe_pkg::xlen-1:0] pc,
  output rv_pipe_pkg::fetch_decode_t to_decode
);
  import rv_pipe_pkg::*;

  logic [xlen-1:0] next_pc;

  // taken branch from execute wins over the sequential step
  always_comb begin
    if (redirect) begin
      next_pc = redirect_pc;
    end else begin
      next_pc = pc + pc_step;
    end
  end

  // pc sits at reset_pc until reset drops
  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= reset_pc;
    end else begin
      pc <= next_pc;
    end
  end

  // fetch to decode register
  always_ff @(posedge clk) begin
    to_decode.pc <= pc;
    to_decode.insn <= insn;
    if (rst) begin
      to_decode.status <= cycle_reset;
    end else if (redirect) begin
      // word fetched behind a taken branch is dropped
      to_decode.status <= cycle_taken_branch;
    end else begin
      to_decode.status <= cycle_no_stall;
    end
  end

endmodule

`default_nettype wire

/* verilog/insn_mem.sv */
`timescale 1ns/10ps
`default_nettype none

module insn_mem (
  input wire clk,
  input wire load_en,
  input wire [7:0] load_addr,
  input wire [31:0] load_data,
  input wire [31:0] pc,
  output logic [31:0] insn
);

  // 256 words of program storage
  logic [31:0] mem [256];

  // word index taken from the byte pc
  logic [7:0] word_idx;

  // load port, one word per clock while held in reset
  always_ff @(posedge clk) begin
    if (load_en) begin
      mem[load_addr] <= load_data;
    end
  end

  // upper pc bits are ignored so fetch wraps around the array
  assign word_idx = pc[9:2];

  // asynchronous read, insn is valid in the same cycle as pc
  assign insn = mem[word_idx];

endmodule

`default_nettype wire

/* verilog/reg_file.sv */
`timescale 1ns/10ps
`default_nettype none

module reg_file (
  input wire clk,
  input wire rst,
  input wire rv_pipe_pkg::reg_write_t wr,
  input wire [rv_pipe_pkg::reg_addr_w-1:0] rs1_addr,
  input wire [rv_pipe_pkg::reg_addr_w-1:0] rs2_addr,
  output logic [rv_pipe_pkg::xlen-1:0] rs1_data,
  output logic [rv_pipe_pkg::xlen-1:0] rs2_data
);
  import rv_pipe_pkg::*;

  logic [xlen-1:0] regs [num_regs];

  // write lands at the edge, reads see it next cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (wr.we) begin
      regs[wr.rd] <= wr.data;
    end
  end

  // x0 is hardwired to zero on both read ports
  assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

`default_nettype wire

/* verilog/retire_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module retire_stage (
  input wire clk,
  input wire rst,
  input wire rv_pipe_pkg::execute_memory_t from_execute,
  output rv_pipe_pkg::reg_write_t mem_fwd,
  output rv_pipe_pkg::reg_write_t wb_write,
  output logic [rv_pipe_pkg::xlen-1:0] trace_pc,
  output logic [rv_pipe_pkg::xlen-1:0] trace_insn,
  output rv_pipe_pkg::cycle_status_e trace_status,
  output logic trace_rd_we,
  output logic [rv_pipe_pkg::reg_addr_w-1:0] trace_rd,
  output logic [rv_pipe_pkg::xlen-1:0] trace_rd_data
);
  import rv_pipe_pkg::*;

  execute_memory_t mem_reg;
  execute_memory_t wb_reg;

  // memory then writeback, one cycle each
  always_ff @(posedge clk) begin
    mem_reg <= from_execute;
    wb_reg <= mem_reg;
    if (rst) begin
      mem_reg.status <= cycle_reset;
      mem_reg.rd_we <= 1'b0;
      wb_reg.status <= cycle_reset;
      wb_reg.rd_we <= 1'b0;
    end
  end

  // forwarding sources for execute and decode
  assign mem_fwd = '{we: mem_reg.rd_we, rd: mem_reg.rd, data: mem_reg.result};
  // also the register file write port
  assign wb_write = '{we: wb_reg.rd_we, rd: wb_reg.rd, data: wb_reg.result};

  // trace shows the writeback register as is
  assign trace_pc = wb_reg.pc;
  assign trace_insn = wb_reg.insn;
  assign trace_status = wb_reg.status;
  assign trace_rd_we = wb_reg.rd_we;
  assign trace_rd = wb_reg.rd;
  assign trace_rd_data = wb_reg.result;

endmodule

`default_nettype wire

/* verilog/rv_pipe_pkg.sv */
`default_nettype none

package rv_pipe_pkg;

  // register and pc width
  localparam int xlen = 32;
  // register index width and register count
  localparam int reg_addr_w = 5;
  localparam int num_regs = 32;

  // instruction memory depth in 32-bit words
  localparam int imem_words = 256;
  localparam int imem_addr_w = 8;

  // first fetch address and sequential step
  localparam logic [xlen-1:0] reset_pc = 32'h0000_0000;
  localparam logic [xlen-1:0] pc_step = 32'd4;

  // major opcodes of the supported subset
  typedef enum logic [6:0] {
    opcode_lui    = 7'b0110111,
    opcode_op_imm = 7'b0010011,
    opcode_op     = 7'b0110011,
    opcode_branch = 7'b1100011
  } opcode_e;

  // decoded operation carried down the pipe
  typedef enum logic [2:0] {
    op_lui,
    op_addi,
    op_add,
    op_beq,
    op_bne,
    op_illegal
  } insn_op_e;

  // what the writeback slot holds in a given cycle
  typedef enum logic [2:0] {
    cycle_reset        = 3'd1,
    cycle_no_stall     = 3'd2,
    cycle_taken_branch = 3'd4
  } cycle_status_e;

  // fetch to decode record
  typedef struct packed {
    logic [xlen-1:0] pc;
    logic [xlen-1:0] insn;
    cycle_status_e   status;
  } fetch_decode_t;

  // decode to execute record
  typedef struct packed {
    logic [xlen-1:0]       pc;
    logic [xlen-1:0]       insn;
    insn_op_e              op;
    logic [reg_addr_w-1:0] rd;
    logic [reg_addr_w-1:0] rs1;
    logic [reg_addr_w-1:0] rs2;
    logic [xlen-1:0]       rs1_data;
    logic [xlen-1:0]       rs2_data;
    // already sign-extended and shifted for the op
    logic [xlen-1:0]       imm;
    logic                  rd_we;
    cycle_status_e         status;
  } decode_execute_t;

  // execute to memory record
  typedef struct packed {
    logic [xlen-1:0]       pc;
    logic [xlen-1:0]       insn;
    logic [reg_addr_w-1:0] rd;
    logic                  rd_we;
    logic [xlen-1:0]       result;
    cycle_status_e         status;
  } execute_memory_t;

  // register write, also used as a forwarding source
  typedef struct packed {
    logic                  we;
    logic [reg_addr_w-1:0] rd;
    logic [xlen-1:0]       data;
  } reg_write_t;

endpackage

`default_nettype wire

/* verilog/rv_pipeline.sv */
`timescale 1ns/10ps
`default_nettype none

module rv_pipeline (
  input wire clk,
  input wire rst,
  input wire load_en,
  input wire [rv_pipe_pkg::imem_addr_w-1:0] load_addr,
  input wire [rv_pipe_pkg::xlen-1:0] load_data,
  output logic [rv_pipe_pkg::xlen-1:0] trace_pc,
  output logic [rv_pipe_pkg::xlen-1:0] trace_insn,
  output rv_pipe_pkg::cycle_status_e trace_status,
  output logic trace_rd_we,
  output logic [rv_pipe_pkg::reg_addr_w-1:0] trace_rd,
  output logic [rv_pipe_pkg::xlen-1:0] trace_rd_data
);
  import rv_pipe_pkg::*;

  // fetch address and returned word
  logic [xlen-1:0] pc;
  logic [xlen-1:0] insn;

  // stage records
  fetch_decode_t fetch_to_decode;
  decode_execute_t decode_to_execute;
  execute_memory_t execute_to_memory;

  // forwarding and write port from retire
  reg_write_t mem_fwd;
  reg_write_t wb_write;

  // taken branch steering fetch and decode
  logic redirect;
  logic [xlen-1:0] redirect_pc;

  insn_mem u_imem (
    .clk       (clk),
    .load_en   (load_en),
    .load_addr (load_addr),
    .load_data (load_data),
    .pc        (pc),
    .insn      (insn)
  );

  fetch_stage u_fetch (
    .clk         (clk),
    .rst         (rst),
    .insn        (insn),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .pc          (pc),
    .to_decode   (fetch_to_decode)
  );

  decode_stage u_decode (
    .clk        (clk),
    .rst        (rst),
    .from_fetch (fetch_to_decode),
    .wb_write   (wb_write),
    .redirect   (redirect),
    .to_execute (decode_to_execute)
  );

  execute_stage u_execute (
    .from_decode (decode_to_execute),
    .mem_fwd     (mem_fwd),
    .wb_write    (wb_write),
    .to_memory   (execute_to_memory),
    .redirect    (redirect),
    .redirect_pc (redirect_pc)
  );

  retire_stage u_retire (
    .clk           (clk),
    .rst           (rst),
    .from_execute  (execute_to_memory),
    .mem_fwd       (mem_fwd),
    .wb_write      (wb_write),
    .trace_pc      (trace_pc),
    .trace_insn    (trace_insn),
    .trace_status  (trace_status),
    .trace_rd_we   (trace_rd_we),
    .trace_rd      (trace_rd),
    .trace_rd_data (trace_rd_data)
  );

endmodule

`default_nettype wire
